/* hdc_consts.svh */
`ifndef HDC_CONSTS_SVH
`define HDC_CONSTS_SVH

// hypervector width in bits
`define HDC_DIM 64

// item memory geometry
`define HDC_ITEM_DEPTH 512
`define HDC_ADDR_W 9

// round-robin hardware threads
`define HDC_THREADS 5

// instruction layout, opcode in the top bits
`define HDC_INSTR_W 16
`define HDC_OP_W 4

// rotate amount, low bits of the operand
`define HDC_ROT_W 6

`endif

/* hdc_pkg.sv */
package hdc_pkg;

    `include "hdc_consts.svh"

    // one hypervector
    typedef logic [`HDC_DIM-1:0] hv_t;

    // item memory address, taken from the low instruction bits
    typedef logic [`HDC_ADDR_W-1:0] item_addr_t;

    // thread slot, counts 0 to HDC_THREADS-1
    typedef logic [$clog2(`HDC_THREADS)-1:0] thread_t;

    // instruction opcodes
    typedef enum logic [`HDC_OP_W-1:0] {
        op_nop     = 4'd0,
        op_load    = 4'd1,
        op_xor     = 4'd2,
        op_move    = 4'd3,
        op_permute = 4'd4,
        op_sign    = 4'd5,
        op_wb_item = 4'd6,
        op_store   = 4'd7,
        op_last    = 4'd8
    } opcode_e;

endpackage

/* item_memory.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdc_consts.svh"

module item_memory (
    input  wire logic               clk,

    // external loading port
    input  wire logic               item_we,
    input  hdc_pkg::item_addr_t     item_addr,
    input  hdc_pkg::hv_t            item_data,

    // accumulator write-back from the core
    input  wire logic               wb_req,
    input  hdc_pkg::item_addr_t     wb_addr,
    input  hdc_pkg::hv_t            wb_data,

    // read port, one cycle latency
    input  hdc_pkg::item_addr_t     rd_addr,
    output hdc_pkg::hv_t            rd_data
);

    (* ram_style = "block" *)
    hdc_pkg::hv_t mem [0:`HDC_ITEM_DEPTH-1];

    // single write port, write-back beats an external write
    always_ff @(posedge clk) begin
        if (wb_req) begin
            mem[wb_addr] <= wb_data;
        end else if (item_we) begin
            mem[item_addr] <= item_data;
        end
    end

    // free-running read, the execute stage picks it up only on a load
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* instr_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdc_consts.svh"

module instr_decode (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   run,

    // instruction strobe, no back-pressure
    input  wire logic                   instr_valid,
    input  wire logic [`HDC_INSTR_W-1:0] instr,

    // execute stage fields
    output logic                        ex_valid,
    output hdc_pkg::opcode_e            ex_op,
    output hdc_pkg::item_addr_t         ex_operand,
    output hdc_pkg::thread_t            ex_thread,

    // write-back request to the item memory
    output logic                        wb_req,
    output hdc_pkg::item_addr_t         wb_addr
);

    hdc_pkg::opcode_e   dec_op;
    hdc_pkg::item_addr_t dec_operand;
    hdc_pkg::thread_t   slot_cnt;

    // field split
    assign dec_op      = hdc_pkg::opcode_e'(instr[`HDC_INSTR_W-1 -: `HDC_OP_W]);
    assign dec_operand = instr[`HDC_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            ex_valid   <= 1'b0;
            ex_op      <= hdc_pkg::op_nop;
            ex_operand <= '0;
            ex_thread  <= '0;
            wb_req     <= 1'b0;
            wb_addr    <= '0;
            slot_cnt   <= '0;
        end else begin
            ex_valid <= instr_valid;
            if (instr_valid) begin
                ex_operand <= dec_operand;
                ex_thread  <= slot_cnt;

                // write-back goes straight to memory, execute sees a nop
                if (dec_op == hdc_pkg::op_wb_item) begin
                    ex_op   <= hdc_pkg::op_nop;
                    wb_req  <= 1'b1;
                    wb_addr <= dec_operand;
                end else begin
                    ex_op   <= dec_op;
                    wb_req  <= 1'b0;
                    wb_addr <= '0;
                end

                // round-robin slot
                if (slot_cnt == hdc_pkg::thread_t'(`HDC_THREADS - 1)) begin
                    slot_cnt <= '0;
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end else begin
                ex_op  <= hdc_pkg::op_nop;
                wb_req <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* thread_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdc_consts.svh"

module thread_regfile (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           run,

    // read side, slot in the execute stage
    input  hdc_pkg::thread_t    rd_thread,
    output hdc_pkg::hv_t        bind_reg,
    output hdc_pkg::hv_t        acc,

    // write side
    input  wire logic           bind_we,
    input  wire logic           acc_we,
    input  hdc_pkg::thread_t    wr_thread,
    input  hdc_pkg::hv_t        wr_data
);

    // reg_1 and reg_2 of every thread
    hdc_pkg::hv_t bind_bank [`HDC_THREADS];
    hdc_pkg::hv_t acc_bank  [`HDC_THREADS];

    // pair of the executing slot
    assign bind_reg = bind_bank[rd_thread];
    assign acc      = acc_bank[rd_thread];

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            for (int i = 0; i < `HDC_THREADS; i++) begin
                bind_bank[i] <= '0;
                acc_bank[i]  <= '0;
            end
        end else begin
            if (bind_we) begin
                bind_bank[wr_thread] <= wr_data;
            end
            if (acc_we) begin
                acc_bank[wr_thread] <= wr_data;
            end
        end
    end

endmodule

`default_nettype wire

/* hdc_execute.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_execute (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               run,

    // decoded instruction
    input  wire logic               ex_valid,
    input  hdc_pkg::opcode_e        ex_op,
    input  hdc_pkg::item_addr_t     ex_operand,
    input  hdc_pkg::thread_t        ex_thread,

    // operands
    input  hdc_pkg::hv_t            mem_word,
    input  hdc_pkg::hv_t            sign_vec,
    input  hdc_pkg::hv_t            bind_reg,
    input  hdc_pkg::hv_t            acc,

    // register write
    output logic                    bind_we,
    output logic                    acc_we,
    output hdc_pkg::thread_t        wr_thread,
    output hdc_pkg::hv_t            wr_data,

    // core outputs, registered
    output logic                    store,
    output hdc_pkg::hv_t            result,
    output logic                    last
);

    logic [`HDC_ROT_W-1:0]  rot_amt;
    logic [2*`HDC_DIM-1:0]  rot_full;
    hdc_pkg::hv_t           acc_rot;
    logic                   do_store;
    logic                   do_last;

    // rotate left, upper half of the doubled word
    assign rot_amt  = ex_operand[`HDC_ROT_W-1:0];
    assign rot_full = {acc, acc} << rot_amt;
    assign acc_rot  = rot_full[2*`HDC_DIM-1:`HDC_DIM];

    assign wr_thread = ex_thread;
    assign do_store  = ex_valid && (ex_op == hdc_pkg::op_store);
    assign do_last   = ex_valid && (ex_op == hdc_pkg::op_last);

    always_comb begin
        bind_we = 1'b0;
        acc_we  = 1'b0;
        wr_data = acc;
        if (ex_valid) begin
            case (ex_op)
                hdc_pkg::op_load: begin
                    acc_we  = 1'b1;
                    wr_data = mem_word;
                end
                hdc_pkg::op_xor: begin
                    acc_we  = 1'b1;
                    wr_data = bind_reg ^ acc;
                end
                hdc_pkg::op_move: begin
                    bind_we = 1'b1;
                    wr_data = acc;
                end
                hdc_pkg::op_permute: begin
                    acc_we  = 1'b1;
                    wr_data = acc_rot;
                end
                hdc_pkg::op_sign: begin
                    acc_we  = 1'b1;
                    wr_data = sign_vec;
                end
                // store, last and nop leave the banks alone
                default: begin
                    bind_we = 1'b0;
                    acc_we  = 1'b0;
                end
            endcase
        end
    end

    // one-cycle pulses, result is zero outside a store
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            store  <= 1'b0;
            result <= '0;
            last   <= 1'b0;
        end else begin
            store  <= do_store;
            result <= do_store ? acc : '0;
            last   <= do_last;
        end
    end

endmodule

`default_nettype wire

/* hdc_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "hdc_consts.svh"

module hdc_core (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    run,

    // item memory loading
    input  wire logic                    item_we,
    input  hdc_pkg::item_addr_t          item_addr,
    input  hdc_pkg::hv_t                 item_data,

    // instruction stream
    input  wire logic                    instr_valid,
    input  wire logic [`HDC_INSTR_W-1:0] instr,
    input  hdc_pkg::hv_t                 sign_vec,

    // results
    output logic                         store,
    output hdc_pkg::hv_t                 result,
    output logic                         last
);

    logic                ex_valid;
    hdc_pkg::opcode_e    ex_op;
    hdc_pkg::item_addr_t ex_operand;
    hdc_pkg::thread_t    ex_thread;
    logic                wb_req;
    hdc_pkg::item_addr_t wb_addr;
    hdc_pkg::hv_t        mem_word;
    hdc_pkg::hv_t        bind_reg;
    hdc_pkg::hv_t        acc;
    logic                bind_we;
    logic                acc_we;
    hdc_pkg::thread_t    wr_thread;
    hdc_pkg::hv_t        wr_data;

    // read address comes from the raw instruction, same cycle as decode
    item_memory u_item_memory (
        .clk       (clk),
        .item_we   (item_we),
        .item_addr (item_addr),
        .item_data (item_data),
        .wb_req    (wb_req),
        .wb_addr   (wb_addr),
        .wb_data   (acc),
        .rd_addr   (instr[`HDC_ADDR_W-1:0]),
        .rd_data   (mem_word)
    );

    instr_decode u_instr_decode (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_operand  (ex_operand),
        .ex_thread   (ex_thread),
        .wb_req      (wb_req),
        .wb_addr     (wb_addr)
    );

    thread_regfile u_thread_regfile (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .rd_thread (ex_thread),
        .bind_reg  (bind_reg),
        .acc       (acc),
        .bind_we   (bind_we),
        .acc_we    (acc_we),
        .wr_thread (wr_thread),
        .wr_data   (wr_data)
    );

    hdc_execute u_hdc_execute (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .ex_valid   (ex_valid),
        .ex_op      (ex_op),
        .ex_operand (ex_operand),
        .ex_thread  (ex_thread),
        .mem_word   (mem_word),
        .sign_vec   (sign_vec),
        .bind_reg   (bind_reg),
        .acc        (acc),
        .bind_we    (bind_we),
        .acc_we     (acc_we),
        .wr_thread  (wr_thread),
        .wr_data    (wr_data),
        .store      (store),
        .result     (result),
        .last       (last)
    );

endmodule

`default_nettype wire

/* tb_hdc_core.sv */
`timescale 1ns/10ps

`include "hdc_consts.svh"

module tb_hdc_core;

    // stimulus runs a few hundred cycles, limit leaves a wide margin
    localparam int MAX_CYCLES = 2000;

    logic                    clk;
    logic                    reset;
    logic                    run;
    logic                    item_we;
    hdc_pkg::item_addr_t     item_addr;
    hdc_pkg::hv_t            item_data;
    logic                    instr_valid;
    logic [`HDC_INSTR_W-1:0] instr;
    hdc_pkg::hv_t            sign_vec;
    logic                    store;
    hdc_pkg::hv_t            result;
    logic                    last;

    // reference model
    hdc_pkg::hv_t mdl_mem  [`HDC_ITEM_DEPTH];
    hdc_pkg::hv_t mdl_bind [`HDC_THREADS];
    hdc_pkg::hv_t mdl_acc  [`HDC_THREADS];
    int           mdl_slot;

    // prediction driven with each instruction, then delayed two cycles
    logic         pred_store;
    logic         pred_last;
    hdc_pkg::hv_t pred_value;
    logic         exp_store_q1;
    logic         exp_store_q2;
    logic         exp_last_q1;
    logic         exp_last_q2;
    hdc_pkg::hv_t exp_value_q1;
    hdc_pkg::hv_t exp_value_q2;

    int cycle_count;

    hdc_core uut (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .item_we     (item_we),
        .item_addr   (item_addr),
        .item_data   (item_data),
        .instr_valid (instr_valid),
        .instr       (instr),
        .sign_vec    (sign_vec),
        .store       (store),
        .result      (result),
        .last        (last)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic hdc_pkg::hv_t random_hv();
        return {$urandom, $urandom};
    endfunction

    // one bit position per step
    function automatic hdc_pkg::hv_t rotate_left(input hdc_pkg::hv_t v, input int amt);
        hdc_pkg::hv_t out;
        out = v;
        for (int i = 0; i < amt; i++) begin
            out = {out[`HDC_DIM-2:0], out[`HDC_DIM-1]};
        end
        return out;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < `HDC_THREADS; i++) begin
            mdl_bind[i] = '0;
            mdl_acc[i]  = '0;
        end
        mdl_slot = 0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_item(input hdc_pkg::item_addr_t addr, input hdc_pkg::hv_t data);
        item_we   = 1'b1;
        item_addr = addr;
        item_data = data;
        mdl_mem[addr] = data;
        @(posedge clk);
        #1;
        item_we = 1'b0;
    endtask

    task automatic issue(input hdc_pkg::opcode_e op, input hdc_pkg::item_addr_t operand);
        int s;
        s = mdl_slot;
        pred_store = 1'b0;
        pred_last  = 1'b0;
        pred_value = '0;
        case (op)
            hdc_pkg::op_load:    mdl_acc[s] = mdl_mem[operand];
            hdc_pkg::op_xor:     mdl_acc[s] = mdl_bind[s] ^ mdl_acc[s];
            hdc_pkg::op_move:    mdl_bind[s] = mdl_acc[s];
            hdc_pkg::op_permute: mdl_acc[s] = rotate_left(mdl_acc[s], operand[`HDC_ROT_W-1:0]);
            hdc_pkg::op_sign:    mdl_acc[s] = sign_vec;
            hdc_pkg::op_wb_item: mdl_mem[operand] = mdl_acc[s];
            hdc_pkg::op_store: begin
                pred_store = 1'b1;
                pred_value = mdl_acc[s];
            end
            hdc_pkg::op_last:    pred_last = 1'b1;
            default: ;
        endcase
        mdl_slot = (s + 1) % `HDC_THREADS;
        instr = '0;
        instr[`HDC_INSTR_W-1 -: `HDC_OP_W] = op;
        instr[`HDC_ADDR_W-1:0] = operand;
        instr_valid = 1'b1;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        pred_store  = 1'b0;
        pred_last   = 1'b0;
        pred_value  = '0;
    endtask

    // one op for the current slot, nops fill the other four
    task automatic issue_padded(input hdc_pkg::opcode_e op, input hdc_pkg::item_addr_t operand);
        issue(op, operand);
        repeat (`HDC_THREADS - 1) issue(hdc_pkg::op_nop, '0);
    endtask

    task automatic clear_with_run_low();
        run = 1'b0;
        @(posedge clk);
        #1;
        run = 1'b1;
        clear_model();
    endtask

    task automatic load_store_roundtrip();
        hdc_pkg::item_addr_t addrs [4];
        addrs[0] = '0;
        addrs[1] = 9'd511;
        addrs[2] = hdc_pkg::item_addr_t'($urandom);
        addrs[3] = hdc_pkg::item_addr_t'($urandom);
        foreach (addrs[i]) write_item(addrs[i], random_hv());
        foreach (addrs[i]) begin
            issue_padded(hdc_pkg::op_load, addrs[i]);
            issue_padded(hdc_pkg::op_store, '0);
        end
    endtask

    task automatic binding_sequence();
        issue_padded(hdc_pkg::op_load, 9'd3);
        issue_padded(hdc_pkg::op_move, '0);
        issue_padded(hdc_pkg::op_load, 9'd4);
        issue_padded(hdc_pkg::op_xor, '0);
        issue_padded(hdc_pkg::op_store, '0);
    endtask

    task automatic thread_isolation();
        for (int k = 0; k < `HDC_THREADS; k++) issue(hdc_pkg::op_load, 9'(10 + k));
        for (int k = 0; k < `HDC_THREADS; k++) issue(hdc_pkg::op_store, '0);
        idle(3);
        clear_with_run_low();
        for (int k = 0; k < `HDC_THREADS; k++) issue(hdc_pkg::op_store, '0);
    endtask

    task automatic permute_amounts();
        int amounts [6];
        amounts = '{0, 1, 17, 32, 63, 0};
        amounts[5] = $urandom_range(63);
        issue_padded(hdc_pkg::op_load, 9'd20);
        foreach (amounts[i]) begin
            issue_padded(hdc_pkg::op_permute, 9'(amounts[i]));
            issue_padded(hdc_pkg::op_store, '0);
        end
    endtask

    task automatic sign_writeback();
        write_item(9'd300, random_hv());
        sign_vec = random_hv();
        issue_padded(hdc_pkg::op_sign, '0);
        issue_padded(hdc_pkg::op_wb_item, 9'd300);
        sign_vec = random_hv();
        // overwrite the accumulator so the store has to come from memory
        issue_padded(hdc_pkg::op_load, 9'd5);
        issue_padded(hdc_pkg::op_load, 9'd300);
        issue_padded(hdc_pkg::op_store, '0);
    endtask

    task automatic last_flag();
        issue(hdc_pkg::op_last, '0);
        idle(3);
        issue(hdc_pkg::op_store, '0);
        issue(hdc_pkg::op_last, '0);
        idle(3);
    endtask

    // expected outputs follow the two-cycle pipeline, cleared like the core
    always @(posedge clk) begin
        if (reset || !run) begin
            exp_store_q1 <= 1'b0;
            exp_store_q2 <= 1'b0;
            exp_last_q1  <= 1'b0;
            exp_last_q2  <= 1'b0;
            exp_value_q1 <= '0;
            exp_value_q2 <= '0;
        end else begin
            exp_store_q1 <= instr_valid && pred_store;
            exp_last_q1  <= instr_valid && pred_last;
            exp_value_q1 <= instr_valid ? pred_value : '0;
            exp_store_q2 <= exp_store_q1;
            exp_last_q2  <= exp_last_q1;
            exp_value_q2 <= exp_value_q1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("timeout: the run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    store_timing: assert property (@(posedge clk) disable iff (reset) store == exp_store_q2)
        else abort_run($sformatf("MISMATCH at %0t: store is %0b, expected %0b",
                                 $time, $sampled(store), $sampled(exp_store_q2)));

    store_value: assert property (@(posedge clk) disable iff (reset)
                                  store |-> result == exp_value_q2)
        else abort_run($sformatf("MISMATCH at %0t: result %h, expected %h",
                                 $time, $sampled(result), $sampled(exp_value_q2)));

    idle_result: assert property (@(posedge clk) disable iff (reset) !store |-> result == '0)
        else abort_run($sformatf("MISMATCH at %0t: result %h while store is low",
                                 $time, $sampled(result)));

    last_timing: assert property (@(posedge clk) disable iff (reset) last == exp_last_q2)
        else abort_run($sformatf("MISMATCH at %0t: last is %0b, expected %0b",
                                 $time, $sampled(last), $sampled(exp_last_q2)));

    initial begin
        void'($urandom(16233));
        reset       = 1'b1;
        run         = 1'b0;
        item_we     = 1'b0;
        item_addr   = '0;
        item_data   = '0;
        instr_valid = 1'b0;
        instr       = '0;
        sign_vec    = '0;
        pred_store  = 1'b0;
        pred_last   = 1'b0;
        pred_value  = '0;
        clear_model();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        run   = 1'b1;

        // words for the load tests
        for (int a = 0; a < 32; a++) write_item(9'(a), random_hv());

        load_store_roundtrip();
        binding_sequence();
        thread_isolation();
        permute_amounts();
        sign_writeback();
        last_flag();
        idle(4);

        $display("test passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+.
hdc_pkg.sv
item_memory.sv
instr_decode.sv
thread_regfile.sv
hdc_execute.sv
hdc_core.sv
tb_hdc_core.sv

/* Bender.yml */
package:
  name: hdc_core

export_include_dirs:
  - .

sources:
  - hdc_pkg.sv
  - item_memory.sv
  - instr_decode.sv
  - thread_regfile.sv
  - hdc_execute.sv
  - hdc_core.sv
  - target: test
    files:
      - tb_hdc_core.sv
